// File: src/compositor_pkg.sv
package compositor_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and counts shared by the whole compositor
	//////////////////////////////////////////////////////////////////////

	localparam int pixel_w = 24;    // Bits per pixel.
	localparam int coord_w = 12;    // Coordinates and sizes.
	localparam int num_layers = 3;

	// Layer FIFO depth, also the initial credit of a layer source.
	localparam int fifo_depth = 4;

	//////////////////////////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////////////////////////

	typedef logic [pixel_w-1:0] pixel_t;
	typedef logic [coord_w-1:0] coord_t;

endpackage

// File: src/pixel_fifo.sv
module pixel_fifo #(
	parameter int DEPTH = compositor_pkg::fifo_depth
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    wr,
	input  compositor_pkg::pixel_t  wr_data,
	input  logic                    rd,
	output compositor_pkg::pixel_t  rd_data,
	output logic                    empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	compositor_pkg::pixel_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;

	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign rd_data = mem[rd_ptr];   // Head of the buffer.

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(wr) - CNT_W'(rd);
		end
	end

	// The source ran ahead of its credits.
	assert property (@(posedge clk) disable iff (!resetn) wr |-> !full)
		else $error("pixel_fifo: write while full");

	// A layer unit popped a pixel that never arrived.
	assert property (@(posedge clk) disable iff (!resetn) rd |-> !empty)
		else $error("pixel_fifo: read while empty");

endmodule

// File: src/layer_unit.sv
module layer_unit #(
	parameter int FIFO_DEPTH = compositor_pkg::fifo_depth
) (
	input  logic                    clk,
	input  logic                    resetn,

	// Pixel stream of this layer, window pixels only.
	input  logic                    in_valid,
	input  compositor_pkg::pixel_t  in_data,
	output logic                    credit,

	// Window placement in the output frame.
	input  compositor_pkg::coord_t  win_left,
	input  compositor_pkg::coord_t  win_top,
	input  compositor_pkg::coord_t  win_width,
	input  compositor_pkg::coord_t  win_height,

	// Shared scan position.
	input  compositor_pkg::coord_t  pos_x,
	input  compositor_pkg::coord_t  pos_y,
	input  logic                    step,

	output logic                    ok,
	output logic                    hit,
	output compositor_pkg::pixel_t  hit_data
);

	localparam int EXT_W = compositor_pkg::coord_w + 1;

	logic [EXT_W-1:0]       win_right;
	logic [EXT_W-1:0]       win_bottom;
	logic                   in_x;
	logic                   in_y;
	logic                   covered;
	logic                   pop;
	logic                   fifo_empty;
	compositor_pkg::pixel_t head;

	//////////////////////////////////////////////////////////////////////
	// Window test
	//////////////////////////////////////////////////////////////////////

	// One bit wider so the far edge cannot wrap.
	assign win_right = EXT_W'(win_left) + EXT_W'(win_width);
	assign win_bottom = EXT_W'(win_top) + EXT_W'(win_height);

	assign in_x = (pos_x >= win_left) && (EXT_W'(pos_x) < win_right);
	assign in_y = (pos_y >= win_top) && (EXT_W'(pos_y) < win_bottom);
	assign covered = in_x && in_y;

	// Ready unless the position needs a pixel we do not have yet.
	assign ok = !covered || !fifo_empty;

	assign pop = step && covered;

	//////////////////////////////////////////////////////////////////////
	// Input buffer
	//////////////////////////////////////////////////////////////////////

	pixel_fifo #(
		.DEPTH   (FIFO_DEPTH)
	) fifo_i (
		.clk     (clk),
		.resetn  (resetn),
		.wr      (in_valid),
		.wr_data (in_data),
		.rd      (pop),
		.rd_data (head),
		.empty   (fifo_empty)
	);

	//////////////////////////////////////////////////////////////////////
	// Hit register and credit return
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			hit <= 1'b0;
			credit <= 1'b0;
		end else begin
			hit <= pop;
			credit <= pop;   // One credit per popped pixel.
		end
	end

	always_ff @(posedge clk) begin
		if (pop)
			hit_data <= head;
	end

endmodule

// File: src/raster_scanner.sv
module raster_scanner #(
	parameter int CREDIT_MAX = 8
) (
	input  logic                                  clk,
	input  logic                                  resetn,
	input  compositor_pkg::coord_t                out_width,
	input  compositor_pkg::coord_t                out_height,
	input  logic                                  out_credit,
	input  logic [compositor_pkg::num_layers-1:0] layers_ok,
	output compositor_pkg::coord_t                pos_x,
	output compositor_pkg::coord_t                pos_y,
	output logic                                  step,
	output logic                                  hit_valid,
	output logic                                  step_sof,
	output logic                                  step_eol
);

	localparam int CNT_W = $clog2(CREDIT_MAX + 1);

	logic [CNT_W-1:0] credits;
	logic             line_end;
	logic             frame_end;

	assign line_end = (pos_x == out_width - 1'b1);
	assign frame_end = (pos_y == out_height - 1'b1);

	// Step only with a sink slot free and every covering layer stocked.
	assign step = (credits != '0) && (&layers_ok);

	always_ff @(posedge clk) begin
		if (!resetn)
			credits <= '0;
		else
			credits <= credits + CNT_W'(out_credit) - CNT_W'(step);
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			pos_x <= '0;
			pos_y <= '0;
		end else if (step) begin
			if (line_end) begin
				pos_x <= '0;
				pos_y <= frame_end ? '0 : pos_y + 1'b1;
			end else begin
				pos_x <= pos_x + 1'b1;
			end
		end
	end

	// Flags of the stepped position, aligned with the layer hits.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			hit_valid <= 1'b0;
			step_sof <= 1'b0;
			step_eol <= 1'b0;
		end else begin
			hit_valid <= step;
			step_sof <= step && (pos_x == '0) && (pos_y == '0);
			step_eol <= step && line_end;
		end
	end

	// Sink granted more slots than it has.
	assert property (@(posedge clk) disable iff (!resetn)
		(out_credit && !step) |-> (credits != CNT_W'(CREDIT_MAX)))
		else $error("raster_scanner: output credit overflow");

endmodule

// File: src/layer_compositor.sv
module layer_compositor (
	input  logic                                  clk,
	input  logic                                  resetn,
	input  logic [compositor_pkg::num_layers-1:0] hit,
	input  compositor_pkg::pixel_t                hit_data [compositor_pkg::num_layers],
	input  logic                                  hit_valid,
	input  logic                                  hit_sof,
	input  logic                                  hit_eol,
	output logic                                  out_valid,
	output logic                                  out_sof,
	output logic                                  out_eol,
	output compositor_pkg::pixel_t                out_data
);

	compositor_pkg::pixel_t sel_data;

	//////////////////////////////////////////////////////////////////////
	// Priority select, highest layer on top
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		sel_data = '0;   // Background.
		for (int i = 0; i < compositor_pkg::num_layers; i++) begin
			if (hit[i])
				sel_data = hit_data[i];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_valid <= 1'b0;
			out_sof <= 1'b0;
			out_eol <= 1'b0;
		end else begin
			out_valid <= hit_valid;
			out_sof <= hit_sof;
			out_eol <= hit_eol;
		end
	end

	always_ff @(posedge clk) begin
		if (hit_valid)
			out_data <= sel_data;
	end

	// Layer hits come only from a scanner step.
	assert property (@(posedge clk) disable iff (!resetn)
		(hit != '0) |-> hit_valid)
		else $error("layer_compositor: layer hit without step");

	// Flags ride only on valid pixels.
	assert property (@(posedge clk) disable iff (!resetn)
		(out_sof || out_eol) |-> out_valid)
		else $error("layer_compositor: flag on idle cycle");

endmodule

// File: src/video_compositor.sv
module video_compositor #(
	parameter int FIFO_DEPTH = compositor_pkg::fifo_depth,
	parameter int CREDIT_MAX = 8
) (
	input  logic                                  clk,
	input  logic                                  resetn,

	// Frame size.
	input  compositor_pkg::coord_t                out_width,
	input  compositor_pkg::coord_t                out_height,

	// Per-layer windows.
	input  compositor_pkg::coord_t                win_left   [compositor_pkg::num_layers],
	input  compositor_pkg::coord_t                win_top    [compositor_pkg::num_layers],
	input  compositor_pkg::coord_t                win_width  [compositor_pkg::num_layers],
	input  compositor_pkg::coord_t                win_height [compositor_pkg::num_layers],

	// Layer streams.
	input  logic [compositor_pkg::num_layers-1:0] layer_valid,
	input  compositor_pkg::pixel_t                layer_data [compositor_pkg::num_layers],
	output logic [compositor_pkg::num_layers-1:0] layer_credit,

	// Output stream.
	input  logic                                  out_credit,
	output logic                                  out_valid,
	output compositor_pkg::pixel_t                out_data,
	output logic                                  out_sof,
	output logic                                  out_eol
);

	compositor_pkg::coord_t                pos_x;
	compositor_pkg::coord_t                pos_y;
	logic                                  step;
	logic                                  hit_valid;
	logic                                  step_sof;
	logic                                  step_eol;
	logic [compositor_pkg::num_layers-1:0] layer_ok;
	logic [compositor_pkg::num_layers-1:0] hit;
	compositor_pkg::pixel_t                hit_data [compositor_pkg::num_layers];

	raster_scanner #(
		.CREDIT_MAX (CREDIT_MAX)
	) scanner_i (
		.clk        (clk),
		.resetn     (resetn),
		.out_width  (out_width),
		.out_height (out_height),
		.out_credit (out_credit),
		.layers_ok  (layer_ok),
		.pos_x      (pos_x),
		.pos_y      (pos_y),
		.step       (step),
		.hit_valid  (hit_valid),
		.step_sof   (step_sof),
		.step_eol   (step_eol)
	);

	for (genvar i = 0; i < compositor_pkg::num_layers; i++) begin : g_layer
		layer_unit #(
			.FIFO_DEPTH (FIFO_DEPTH)
		) layer_i (
			.clk        (clk),
			.resetn     (resetn),
			.in_valid   (layer_valid[i]),
			.in_data    (layer_data[i]),
			.credit     (layer_credit[i]),
			.win_left   (win_left[i]),
			.win_top    (win_top[i]),
			.win_width  (win_width[i]),
			.win_height (win_height[i]),
			.pos_x      (pos_x),
			.pos_y      (pos_y),
			.step       (step),
			.ok         (layer_ok[i]),
			.hit        (hit[i]),
			.hit_data   (hit_data[i])
		);
	end

	layer_compositor compositor_i (
		.clk       (clk),
		.resetn    (resetn),
		.hit       (hit),
		.hit_data  (hit_data),
		.hit_valid (hit_valid),
		.hit_sof   (step_sof),
		.hit_eol   (step_eol),
		.out_valid (out_valid),
		.out_sof   (out_sof),
		.out_eol   (out_eol),
		.out_data  (out_data)
	);

endmodule

// File: sim/clock_gen.sv
module clock_gen #(
	parameter int RESET_CYCLES = 16
) (
	output logic clk,
	output logic resetn
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;   // 20 ns period.
	end

	// Released on a falling edge, clear of the sampling edge.
	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
	end

endmodule

// File: sim/compositor_tb.sv
module compositor_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NL = compositor_pkg::num_layers;
	localparam int FIFO_DEPTH = compositor_pkg::fifo_depth;
	localparam int RESET_CYCLES = 16;
	localparam int SINK_SLOTS = 4;     // Below CREDIT_MAX of the DUT.
	localparam int QUIET_CYCLES = 6;
	localparam int MAX_PIX = 64;

	logic                   clk;
	logic                   resetn;
	compositor_pkg::coord_t out_width;
	compositor_pkg::coord_t out_height;
	compositor_pkg::coord_t win_left [NL];
	compositor_pkg::coord_t win_top [NL];
	compositor_pkg::coord_t win_width [NL];
	compositor_pkg::coord_t win_height [NL];
	logic [NL-1:0]          layer_valid;
	compositor_pkg::pixel_t layer_data [NL];
	logic [NL-1:0]          layer_credit;
	logic                   out_credit;
	logic                   out_valid;
	compositor_pkg::pixel_t out_data;
	logic                   out_sof;
	logic                   out_eol;

	// Current test.
	int                     fd;
	string                  test_name;
	int                     frame_w;
	int                     frame_h;
	int                     frames;
	int                     jitter;   // Largest random delay, 0 for none.
	compositor_pkg::pixel_t layer_pix [NL][MAX_PIX];
	int                     layer_len [NL];
	compositor_pkg::pixel_t expect_pix [MAX_PIX];
	int                     expect_len;
	int                     credit_count [NL];
	bit                     sink_done;   // Sink has every pixel of the test.
	int                     cycle_count = 0;
	int                     cycle_limit = RESET_CYCLES;

	clock_gen #(.RESET_CYCLES(RESET_CYCLES)) clock_gen_i (.clk(clk), .resetn(resetn));

	video_compositor #(
		.FIFO_DEPTH (FIFO_DEPTH),
		.CREDIT_MAX (8)
	) video_compositor_i (.*);

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "compositor_tb stopped on the first error");
	endtask

	task automatic check_pixel(input string what, input compositor_pkg::pixel_t expected,
		input compositor_pkg::pixel_t actual);
		if (actual !== expected) begin
			$display("ERROR %s %s: expected %06h, actual %06h", test_name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_flag(input string what, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s %s: expected %b, actual %b", test_name, what, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (actual != expected) begin
			$display("ERROR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Vector file
	//////////////////////////////////////////////////////////////////////

	task automatic next_token(output string tok);
		string rest;
		int    n;
		n = $fscanf(fd, "%s", tok);
		while (n == 1 && tok.substr(0, 0) == "#") begin
			n = $fgets(rest, fd);   // Rest of a comment line.
			n = $fscanf(fd, "%s", tok);
		end
		if (n != 1)
			tok = "";
	endtask

	task automatic load_test(output bit found);
		string tok;
		int    n;
		next_token(tok);
		found = (tok == "test");
		if (!found && tok != "") begin
			$display("Vector file holds '%s' where a test should start", tok);
			abort_run();
		end
		if (found) begin
			next_token(test_name);
			n = $fscanf(fd, "%d %d %d %d", frame_w, frame_h, frames, jitter);
			out_width = compositor_pkg::coord_t'(frame_w);
			out_height = compositor_pkg::coord_t'(frame_h);
			next_token(tok);   // Windows.
			for (int l = 0; l < NL; l++)
				n = $fscanf(fd, "%d %d %d %d", win_left[l], win_top[l], win_width[l],
					win_height[l]);
			for (int l = 0; l < NL; l++) begin
				next_token(tok);
				n = $fscanf(fd, "%d", layer_len[l]);
				for (int k = 0; k < layer_len[l]; k++)
					n = $fscanf(fd, "%h", layer_pix[l][k]);
			end
			next_token(tok);
			n = $fscanf(fd, "%d", expect_len);
			for (int k = 0; k < expect_len; k++)
				n = $fscanf(fd, "%h", expect_pix[k]);
			if (expect_len != frame_w * frame_h * frames) begin
				$display("Test %s lists %0d expected pixels, not %0d frames of %0d by %0d",
					test_name, expect_len, frames, frame_w, frame_h);
				abort_run();
			end
			cycle_limit += 20 * expect_len;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Layer sources and output sink
	//////////////////////////////////////////////////////////////////////

	task automatic drive_layer(input int l);
		int credits;
		int sent;
		credits = FIFO_DEPTH;
		sent = 0;
		credit_count[l] = 0;
		while (sent < layer_len[l] || !sink_done) begin
			@(negedge clk);
			if (layer_credit[l]) begin
				credits++;
				credit_count[l]++;
			end
			if (credits > FIFO_DEPTH) begin
				$display("Layer %0d returned more credits than it was given", l);
				abort_run();
			end
			layer_valid[l] = 1'b0;
			if (credits > 0 && sent < layer_len[l] && $urandom_range(jitter, 0) == 0) begin
				layer_valid[l] = 1'b1;
				layer_data[l] = layer_pix[l][sent];
				credits--;
				sent++;
			end
		end
	endtask

	task automatic run_sink();
		int granted;
		int received;
		int free_slots;
		int hold;
		int pos;
		granted = 0;
		received = 0;
		free_slots = SINK_SLOTS;
		hold = QUIET_CYCLES;
		while (received < expect_len) begin
			@(negedge clk);
			if (granted == 0) begin
				for (int l = 0; l < NL; l++)
					check_flag($sformatf("layer %0d credit before output credit", l), 1'b0,
						layer_credit[l]);
			end
			if (out_valid) begin
				if (received >= granted) begin
					$display("Test %s sent more output pixels than it was granted credits",
						test_name);
					abort_run();
				end
				pos = received % (frame_w * frame_h);
				check_pixel($sformatf("pixel %0d", received), expect_pix[received], out_data);
				check_flag($sformatf("sof of pixel %0d", received), pos == 0, out_sof);
				check_flag($sformatf("eol of pixel %0d", received),
					pos % frame_w == frame_w - 1, out_eol);
				received++;
				free_slots++;
			end
			out_credit = 1'b0;
			if (hold > 0) begin
				hold--;
			end else if (free_slots > 0 && granted < expect_len) begin
				out_credit = 1'b1;
				granted++;
				free_slots--;
				hold = $urandom_range(jitter, 0);
			end
		end
		@(posedge clk);
		sink_done = 1'b1;
	endtask

	task automatic run_test();
		sink_done = 1'b0;
		fork
			drive_layer(0);
			drive_layer(1);
			drive_layer(2);
			run_sink();
		join
		for (int l = 0; l < NL; l++)
			check_count($sformatf("layer %0d credits", l),
				int'(win_width[l]) * int'(win_height[l]) * frames, credit_count[l]);
		$display("Test %s: %0d pixels checked", test_name, expect_len);
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Run timed out after %0d clock cycles without finishing", cycle_count);
			abort_run();
		end
	end

	initial begin
		bit found;
		void'($urandom(32'hcf4d_48a7));
		out_width = '0;
		out_height = '0;
		for (int l = 0; l < NL; l++) begin
			win_left[l] = '0;
			win_top[l] = '0;
			win_width[l] = '0;
			win_height[l] = '0;
			layer_data[l] = '0;
		end
		layer_valid = '0;
		out_credit = 1'b0;
		fd = $fopen("sim/compositor_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the vector file sim/compositor_vectors.txt");
			abort_run();
		end
		load_test(found);
		if (!found) begin
			$display("Vector file holds no tests");
			abort_run();
		end
		wait (resetn === 1'b1);
		while (found) begin
			run_test();
			load_test(found);
		end
		$fclose(fd);
		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: video_compositor.f
src/compositor_pkg.sv
src/pixel_fifo.sv
src/layer_unit.sv
src/raster_scanner.sv
src/layer_compositor.sv
src/video_compositor.sv
sim/clock_gen.sv
sim/compositor_tb.sv

// File: sim/compositor_vectors.txt
# test <name> <width> <height> <frames> <max delay>, win <left top width height> per layer
# layer <count> <hex pixels> for layers 0..2, expect <count> <hex output pixels> in raster order

# One layer covering the whole frame.
test full_frame 4 3 1 0
win 0 0 4 3  0 0 0 0  0 0 0 0
layer 12 a00000 a00001 a00002 a00003 a00004 a00005 a00006 a00007 a00008 a00009 a0000a a0000b
layer 0
layer 0
expect 12
a00000 a00001 a00002 a00003
a00004 a00005 a00006 a00007
a00008 a00009 a0000a a0000b

# Overlapping windows, highest layer on top, zero where uncovered.
test overlap 6 4 1 0
win 0 0 4 3  2 1 3 2  3 2 2 2
layer 12 a00000 a00001 a00002 a00003 a00004 a00005 a00006 a00007 a00008 a00009 a0000a a0000b
layer 6 b10000 b10001 b10002 b10003 b10004 b10005
layer 4 c20000 c20001 c20002 c20003
expect 24
a00000 a00001 a00002 a00003 000000 000000
a00004 a00005 b10000 b10001 b10002 000000
a00008 a00009 b10003 c20000 c20001 000000
000000 000000 000000 c20002 c20003 000000

# Same layout with random credit delays and input gaps.
test random_gaps 6 4 1 3
win 0 0 4 3  2 1 3 2  3 2 2 2
layer 12 110000 110001 110002 110003 110004 110005 110006 110007 110008 110009 11000a 11000b
layer 6 220000 220001 220002 220003 220004 220005
layer 4 330000 330001 330002 330003
expect 24
110000 110001 110002 110003 000000 000000
110004 110005 220000 220001 220002 000000
110008 110009 220003 330000 330001 000000
000000 000000 000000 330002 330003 000000

# Two frames back to back with new data in the second.
test two_frames 4 2 2 2
win 0 0 3 2  0 0 0 0  2 1 2 1
layer 12 400000 400001 400002 400003 400004 400005 500000 500001 500002 500003 500004 500005
layer 0
layer 4 600000 600001 700000 700001
expect 16
400000 400001 400002 000000
400003 400004 600000 600001
500000 500001 500002 000000
500003 500004 700000 700001
